// ==== Makefile ====
# Verilator build and run of the binary16 FMA testbench
TOP = fma_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -sv --assert -Wno-fatal --top-module $(TOP) -Mdir $(OBJ) -f fma_top.f

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

// ==== design/fma_mant_datapath.sv ====
/* FMA mantissa datapath
   Exponent logic, multiplier, addend alignment and adder of the first stage */
`default_nettype none

`include "fma_settings.svh"

module fma_mant_datapath (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 valid_i,
  input  fma_pkg::round_mode_e rnd_mode_i,
  input  fma_pkg::fp16_t       op_a_i,
  input  fma_pkg::fp16_t       op_b_i,
  input  fma_pkg::fp16_t       op_c_i,
  input  fma_pkg::op_class_t   class_a_i,
  input  fma_pkg::op_class_t   class_b_i,
  input  fma_pkg::op_class_t   class_c_i,
  output logic                 valid_o,
  output fma_pkg::round_mode_e rnd_mode_o,
  output fma_pkg::sum_t        sum_o,
  output logic                 eff_sub_o,
  output logic                 sign_o,
  output fma_pkg::exp_t        exp_product_o,
  output fma_pkg::exp_t        exp_diff_o,
  output fma_pkg::exp_t        tent_exp_o,
  output fma_pkg::shamt_t      addend_shamt_o,
  output logic                 sticky_o
);

  import fma_pkg::*;

  // --------------------
  // Exponents
  // --------------------
  exp_t   exponent_a;
  exp_t   exponent_b;
  exp_t   exponent_c;
  exp_t   exp_addend;
  exp_t   exp_product;
  exp_t   exp_diff;
  exp_t   tent_exp;
  shamt_t addend_shamt;

  assign exponent_a = exp_t'(op_a_i[`FMA_EXP]);
  assign exponent_b = exp_t'(op_b_i[`FMA_EXP]);
  assign exponent_c = exp_t'(op_c_i[`FMA_EXP]);
  // Subnormals and zero sit at biased exponent 1
  assign exp_addend = exponent_c + exp_t'(!class_c_i[`FMA_CLS_NORMAL]);
  // Zero product pinned to the minimum exponent
  assign exp_product = (class_a_i[`FMA_CLS_ZERO] || class_b_i[`FMA_CLS_ZERO])
                     ? exp_t'(2 - `FMA_BIAS)
                     : exponent_a + exp_t'(class_a_i[`FMA_CLS_SUB])
                       + exponent_b + exp_t'(class_b_i[`FMA_CLS_SUB]) - exp_t'(`FMA_BIAS);
  assign exp_diff = exp_addend - exp_product;
  assign tent_exp = (exp_diff > 0) ? exp_addend : exp_product;

  // Right shift of the addend, saturated on both ends
  always_comb begin : addend_shift_amount
    if (exp_diff <= -2 * `FMA_PREC_BITS - 1) begin
      // Addend lands entirely in the sticky bit
      addend_shamt = shamt_t'(`FMA_SUM_BITS);
    end else if (exp_diff <= `FMA_PREC_BITS + 2) begin
      addend_shamt = shamt_t'(`FMA_PREC_BITS + 3 - exp_diff);
    end else begin
      // Product lands below the addend
      addend_shamt = '0;
    end
  end

  // --------------------
  // Multiply and align
  // --------------------
  mant_t                                      mant_a;
  mant_t                                      mant_b;
  mant_t                                      mant_c;
  logic [2*`FMA_PREC_BITS-1:0]                product;
  sum_t                                       product_shifted;
  logic [`FMA_SUM_BITS+`FMA_PREC_BITS-1:0]    addend_full;
  sum_t                                       addend_aligned;
  logic                                       sticky_before_add;
  logic                                       eff_sub;
  logic                                       tent_sign;

  // Hidden bits from the normal class
  assign mant_a = {class_a_i[`FMA_CLS_NORMAL], op_a_i[`FMA_MAN]};
  assign mant_b = {class_b_i[`FMA_CLS_NORMAL], op_b_i[`FMA_MAN]};
  assign mant_c = {class_c_i[`FMA_CLS_NORMAL], op_c_i[`FMA_MAN]};

  assign product = mant_a * mant_b;
  // p+2 zeros, 2p product, then round and sticky positions
  assign product_shifted = `FMA_SUM_BITS'({product, 2'b00});

  // Up to p bits fall off the bottom into the sticky field
  assign addend_full       = {mant_c, `FMA_SUM_BITS'(0)} >> addend_shamt;
  assign addend_aligned    = addend_full[`FMA_SUM_BITS+`FMA_PREC_BITS-1:`FMA_PREC_BITS];
  assign sticky_before_add = |addend_full[`FMA_PREC_BITS-1:0];

  assign tent_sign = op_a_i[`FMA_SIGN] ^ op_b_i[`FMA_SIGN];
  assign eff_sub   = tent_sign ^ op_c_i[`FMA_SIGN];

  // --------------------
  // Adder
  // --------------------
  sum_t                   addend_op;
  logic                   carry_in;
  logic [`FMA_SUM_BITS:0] sum_raw;
  logic [`FMA_SUM_BITS:0] sum_neg;
  logic                   sum_carry;
  sum_t                   sum;
  logic                   final_sign;

  // Two's complement subtraction, carry dropped when sticky bits were lost
  assign addend_op = eff_sub ? ~addend_aligned : addend_aligned;
  assign carry_in  = eff_sub & ~sticky_before_add;
  assign sum_raw   = product_shifted + addend_op + carry_in;
  assign sum_neg   = -sum_raw;
  assign sum_carry = sum_raw[`FMA_SUM_BITS];
  // Missing carry on a subtraction means the addend was larger
  assign sum = (eff_sub && !sum_carry) ? sum_neg[`FMA_SUM_BITS-1:0]
                                       : sum_raw[`FMA_SUM_BITS-1:0];
  assign final_sign = eff_sub ? (sum_carry == tent_sign) : tent_sign;

  // --------------------
  // Stage 1 registers
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rnd_mode_o     <= rnd_mode_i;
      sum_o          <= sum;
      eff_sub_o      <= eff_sub;
      sign_o         <= final_sign;
      exp_product_o  <= exp_product;
      exp_diff_o     <= exp_diff;
      tent_exp_o     <= tent_exp;
      addend_shamt_o <= addend_shamt;
      sticky_o       <= sticky_before_add;
    end
  end

  // The undo shift in the second stage must stay inside the sum
  shamt_range_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o |-> addend_shamt_o <= shamt_t'(`FMA_SUM_BITS));

endmodule

`default_nettype wire

// ==== design/fma_norm_round.sv ====
/* FMA normalization and rounding
   Second stage: normalize, round once, merge with the special path */
`default_nettype none

`include "fma_settings.svh"

module fma_norm_round (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 valid_i,
  input  fma_pkg::round_mode_e rnd_mode_i,
  input  fma_pkg::sum_t        sum_i,
  input  logic                 eff_sub_i,
  input  logic                 sign_i,
  input  fma_pkg::exp_t        exp_product_i,
  input  fma_pkg::exp_t        exp_diff_i,
  input  fma_pkg::exp_t        tent_exp_i,
  input  fma_pkg::shamt_t      addend_shamt_i,
  input  logic                 sticky_i,
  input  logic                 is_special_i,
  input  fma_pkg::fp16_t       special_result_i,
  input  fma_pkg::flags_t      special_flags_i,
  output fma_pkg::fp16_t       result_o,
  output fma_pkg::flags_t      flags_o,
  output logic                 out_valid_o
);

  import fma_pkg::*;

  localparam int unsigned LOW_W = 2 * `FMA_PREC_BITS + 3;
  localparam int unsigned ABS_W = `FMA_EXP_BITS + `FMA_MAN_BITS;

  // --------------------
  // Normalization
  // --------------------
  logic [LOW_W-1:0]         sum_lower;
  logic [`FMA_LZC_BITS-1:0] lzc;
  logic                     lzc_zeroes;
  exp_t                     lzc_sgn;
  shamt_t                   norm_shamt;
  exp_t                     norm_exp;
  logic [`FMA_SUM_BITS:0]   sum_shifted;
  logic [`FMA_PREC_BITS:0]  final_mant;
  logic [LOW_W-1:0]         sum_sticky;
  exp_t                     final_exp;
  logic                     sticky_after;

  assign sum_lower = sum_i[LOW_W-1:0];

  // Leading zeros from the top of the lower sum
  always_comb begin : lead_zero_count
    lzc        = '0;
    lzc_zeroes = 1'b1;
    for (int i = LOW_W - 1; i >= 0; i--) begin
      if (lzc_zeroes && sum_lower[i]) begin
        lzc        = `FMA_LZC_BITS'(LOW_W - 1 - i);
        lzc_zeroes = 1'b0;
      end
    end
  end

  assign lzc_sgn = exp_t'(lzc);

  always_comb begin : norm_shift_amount
    // Product anchored, or close enough that cancellation is possible
    if ((exp_diff_i <= 0) || (eff_sub_i && (exp_diff_i <= 2))) begin
      if ((exp_product_i - lzc_sgn + 1 >= 0) && !lzc_zeroes) begin
        norm_shamt = shamt_t'(`FMA_PREC_BITS + 2 + lzc);
        norm_exp   = exp_product_i - lzc_sgn + 1;
      end else begin
        // Subnormal result, shift capped at the minimum exponent
        norm_shamt = shamt_t'(`FMA_PREC_BITS + 2 + exp_product_i);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt = addend_shamt_i;
      norm_exp   = tent_exp_i;
    end
  end

  assign sum_shifted = {1'b0, sum_i} << norm_shamt;

  // Leading one may still sit one position off
  always_comb begin : small_norm
    {final_mant, sum_sticky} = sum_shifted[`FMA_SUM_BITS-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[`FMA_SUM_BITS]) begin
      {final_mant, sum_sticky} = sum_shifted[`FMA_SUM_BITS:1];
      final_exp                = norm_exp + 1;
    end else if (!sum_shifted[`FMA_SUM_BITS-1] && (norm_exp > 1)) begin
      {final_mant, sum_sticky} = {sum_shifted[`FMA_SUM_BITS-2:0], 1'b0};
      final_exp                = norm_exp - 1;
    end else if (!sum_shifted[`FMA_SUM_BITS-1]) begin
      final_exp = '0;
    end
  end

  assign sticky_after = (|sum_sticky) | sticky_i;

  // --------------------
  // Rounding
  // --------------------
  logic                     of_before;
  logic [`FMA_EXP_BITS-1:0] pre_exp;
  logic [`FMA_MAN_BITS-1:0] pre_man;
  logic [ABS_W-1:0]         pre_abs;
  logic [1:0]               round_sticky;
  logic                     round_up;
  logic [ABS_W-1:0]         rounded_abs;
  logic                     exact_zero;
  logic                     rounded_sign;
  logic                     of_after;
  logic                     uf_after;
  logic                     inexact;

  // Overflow saturates to the largest normal, rounding then decides on inf
  assign of_before    = final_exp >= (2 ** `FMA_EXP_BITS) - 1;
  assign pre_exp      = of_before ? `FMA_EXP_BITS'((2 ** `FMA_EXP_BITS) - 2)
                                  : final_exp[`FMA_EXP_BITS-1:0];
  // Bit 0 of the final mantissa is the round bit
  assign pre_man      = of_before ? '1 : final_mant[`FMA_MAN_BITS:1];
  assign pre_abs      = {pre_exp, pre_man};
  assign round_sticky = of_before ? 2'b11 : {final_mant[0], sticky_after};

  always_comb begin : round_decision
    case (rnd_mode_i)
      RNE:     round_up = round_sticky[1] & (round_sticky[0] | pre_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|round_sticky) & sign_i;
      RUP:     round_up = (|round_sticky) & ~sign_i;
      default: round_up = 1'b0;
    endcase
  end

  // Carry out of the mantissa bumps the exponent
  assign rounded_abs = pre_abs + ABS_W'(round_up);
  // Exact cancellation: +0, or -0 when rounding down
  assign exact_zero   = (rounded_abs == '0) && (round_sticky == 2'b00);
  assign rounded_sign = (exact_zero && eff_sub_i) ? (rnd_mode_i == RDN) : sign_i;

  assign of_after = (rounded_abs[ABS_W-1:`FMA_MAN_BITS] == '1);
  assign uf_after = (rounded_abs[ABS_W-1:`FMA_MAN_BITS] == '0);
  assign inexact  = (|round_sticky) | of_before | of_after;

  // --------------------
  // Result select
  // --------------------
  fp16_t  regular_result;
  flags_t regular_flags;

  assign regular_result = {rounded_sign, rounded_abs};

  always_comb begin : regular_status
    regular_flags                = '0;
    regular_flags[`FMA_FLAG_OF] = of_before | of_after;
    // Tininess after rounding, only for inexact results
    regular_flags[`FMA_FLAG_UF] = uf_after & inexact;
    regular_flags[`FMA_FLAG_NX] = inexact;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= is_special_i ? special_result_i : regular_result;
      flags_o  <= is_special_i ? special_flags_i : regular_flags;
    end
  end

  out_valid_known_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(out_valid_o));

endmodule

`default_nettype wire

// ==== design/fma_operand_prep.sv ====
/* FMA operand preparation
   Classifies the three operands and adjusts them for the selected operation */
`default_nettype none

`include "fma_settings.svh"

module fma_operand_prep (
  input  fma_pkg::fp16_t       operand_a_i,
  input  fma_pkg::fp16_t       operand_b_i,
  input  fma_pkg::fp16_t       operand_c_i,
  input  fma_pkg::fma_op_e     op_i,
  input  logic                 op_mod_i,
  input  fma_pkg::round_mode_e rnd_mode_i,
  output fma_pkg::fp16_t       op_a_o,
  output fma_pkg::fp16_t       op_b_o,
  output fma_pkg::fp16_t       op_c_o,
  output fma_pkg::op_class_t   class_a_o,
  output fma_pkg::op_class_t   class_b_o,
  output fma_pkg::op_class_t   class_c_o
);

  import fma_pkg::*;

  // Class bits of one encoded value
  function automatic op_class_t classify(input fp16_t value);
    logic      exp_zero;
    logic      exp_ones;
    logic      man_zero;
    op_class_t cls;
    exp_zero = (value[`FMA_EXP] == '0);
    exp_ones = (value[`FMA_EXP] == '1);
    man_zero = (value[`FMA_MAN] == '0);
    cls = '0;
    cls[`FMA_CLS_ZERO]   = exp_zero & man_zero;
    cls[`FMA_CLS_SUB]    = exp_zero & ~man_zero;
    cls[`FMA_CLS_NORMAL] = ~exp_zero & ~exp_ones;
    cls[`FMA_CLS_INF]    = exp_ones & man_zero;
    cls[`FMA_CLS_NAN]    = exp_ones & ~man_zero;
    // Quiet bit is the mantissa MSB
    cls[`FMA_CLS_SNAN]   = exp_ones & ~man_zero & ~value[`FMA_MAN_BITS-1];
    return cls;
  endfunction

  always_comb begin : op_select
    op_a_o    = operand_a_i;
    op_b_o    = operand_b_i;
    op_c_o    = operand_c_i;
    class_a_o = classify(operand_a_i);
    class_b_o = classify(operand_b_i);
    class_c_o = classify(operand_c_i);
    // Modifier always negates the addend
    op_c_o[`FMA_SIGN] = operand_c_i[`FMA_SIGN] ^ op_mod_i;
    unique case (op_i)
      FMADD: ;
      // Negated product
      FNMSUB: op_a_o[`FMA_SIGN] = ~operand_a_i[`FMA_SIGN];
      // Multiplicand becomes +1.0
      ADD: begin
        op_a_o    = {1'b0, `FMA_EXP_BITS'(`FMA_BIAS), `FMA_MAN_BITS'(0)};
        class_a_o = op_class_t'(1 << `FMA_CLS_NORMAL);
      end
      // Addend becomes a zero that leaves the product sign intact
      MUL: begin
        op_c_o    = {(rnd_mode_i != RDN), `FMA_EXP_BITS'(0), `FMA_MAN_BITS'(0)};
        class_c_o = op_class_t'(1 << `FMA_CLS_ZERO);
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/fma_pkg.sv ====
/* FMA package
   Vector types for the binary16 datapath, operation and rounding mode enums */
`default_nettype none

`include "fma_settings.svh"

package fma_pkg;

  // --------------------
  // Datapath vectors
  // --------------------
  typedef logic [`FMA_WIDTH-1:0]             fp16_t;
  // Biased exponent, signed so that it can go below zero
  typedef logic signed [`FMA_EXP_WIDTH-1:0]  exp_t;
  typedef logic [`FMA_SHAMT_BITS-1:0]        shamt_t;
  typedef logic [`FMA_SUM_BITS-1:0]          sum_t;
  // Mantissa including the hidden bit
  typedef logic [`FMA_PREC_BITS-1:0]         mant_t;
  typedef logic [`FMA_FLAG_BITS-1:0]         flags_t;
  typedef logic [`FMA_CLASS_BITS-1:0]        op_class_t;

  // --------------------
  // Control encodings
  // --------------------
  // Modifier bit selects FMSUB, FNMADD and SUB
  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } fma_op_e;

  // RISC-V rounding mode codes
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3
  } round_mode_e;

endpackage

`default_nettype wire

// ==== design/fma_settings.svh ====
/* FMA settings
   binary16 format, internal datapath widths, field slices and bit positions */
`ifndef FMA_SETTINGS_SVH
`define FMA_SETTINGS_SVH

// binary16 format
`define FMA_EXP_BITS   5
`define FMA_MAN_BITS   10
`define FMA_WIDTH      16
`define FMA_BIAS       15
`define FMA_PREC_BITS  11

// Field slices of an encoded operand
`define FMA_SIGN       15
`define FMA_EXP        14:10
`define FMA_MAN        9:0

// Canonical quiet NaN and infinity magnitude
`define FMA_QNAN       16'h7E00
`define FMA_INF_ABS    15'h7C00

// Internal datapath, sum is 3p+4 wide
`define FMA_SUM_BITS   37
`define FMA_EXP_WIDTH  7
`define FMA_SHAMT_BITS 6
`define FMA_LZC_BITS   5

// Operand class bits
`define FMA_CLASS_BITS 6
`define FMA_CLS_ZERO   0
`define FMA_CLS_SUB    1
`define FMA_CLS_NORMAL 2
`define FMA_CLS_INF    3
`define FMA_CLS_NAN    4
`define FMA_CLS_SNAN   5

// Status flags
`define FMA_FLAG_BITS  4
`define FMA_FLAG_NV    3
`define FMA_FLAG_OF    2
`define FMA_FLAG_UF    1
`define FMA_FLAG_NX    0

`endif

// ==== design/fma_special_case.sv ====
/* FMA special case detection
   NaN, invalid operation and infinity results that bypass the arithmetic */
`default_nettype none

`include "fma_settings.svh"

module fma_special_case (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                valid_i,
  input  fma_pkg::fp16_t      op_a_i,
  input  fma_pkg::fp16_t      op_b_i,
  input  fma_pkg::fp16_t      op_c_i,
  input  fma_pkg::op_class_t  class_a_i,
  input  fma_pkg::op_class_t  class_b_i,
  input  fma_pkg::op_class_t  class_c_i,
  output logic                is_special_o,
  output fma_pkg::fp16_t      special_result_o,
  output fma_pkg::flags_t     special_flags_o
);

  import fma_pkg::*;

  logic   any_nan;
  logic   any_snan;
  logic   prod_inf;
  logic   inf_times_zero;
  logic   eff_sub;
  logic   prod_sign;
  logic   is_special;
  fp16_t  special_result;
  flags_t special_flags;

  // Reductions over the operand classes
  assign any_nan  = class_a_i[`FMA_CLS_NAN] | class_b_i[`FMA_CLS_NAN] | class_c_i[`FMA_CLS_NAN];
  assign any_snan = class_a_i[`FMA_CLS_SNAN] | class_b_i[`FMA_CLS_SNAN]
                  | class_c_i[`FMA_CLS_SNAN];
  assign prod_inf = class_a_i[`FMA_CLS_INF] | class_b_i[`FMA_CLS_INF];
  assign inf_times_zero = (class_a_i[`FMA_CLS_INF] & class_b_i[`FMA_CLS_ZERO])
                        | (class_a_i[`FMA_CLS_ZERO] & class_b_i[`FMA_CLS_INF]);
  assign prod_sign = op_a_i[`FMA_SIGN] ^ op_b_i[`FMA_SIGN];
  assign eff_sub   = prod_sign ^ op_c_i[`FMA_SIGN];

  // Priority chain, default result is the canonical qNaN
  always_comb begin : special_select
    is_special     = 1'b1;
    special_result = `FMA_QNAN;
    special_flags  = '0;
    if (inf_times_zero) begin
      // Invalid even when the addend is a quiet NaN
      special_flags[`FMA_FLAG_NV] = 1'b1;
    end else if (any_nan) begin
      special_flags[`FMA_FLAG_NV] = any_snan;
    end else if (prod_inf && class_c_i[`FMA_CLS_INF] && eff_sub) begin
      // inf - inf
      special_flags[`FMA_FLAG_NV] = 1'b1;
    end else if (prod_inf) begin
      special_result = {prod_sign, `FMA_INF_ABS};
    end else if (class_c_i[`FMA_CLS_INF]) begin
      special_result = {op_c_i[`FMA_SIGN], `FMA_INF_ABS};
    end else begin
      is_special = 1'b0;
    end
  end

  // Bypass select for the second stage
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      is_special_o <= 1'b0;
    end else if (valid_i) begin
      is_special_o <= is_special;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      special_result_o <= special_result;
      special_flags_o  <= special_flags;
    end
  end

endmodule

`default_nettype wire

// ==== design/fma_top.sv ====
/* FMA top level
   binary16 fused multiply-add with a fixed two-cycle pipeline */
`default_nettype none

`include "fma_settings.svh"

module fma_top (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 in_valid_i,
  input  fma_pkg::fp16_t       operand_a_i,
  input  fma_pkg::fp16_t       operand_b_i,
  input  fma_pkg::fp16_t       operand_c_i,
  input  fma_pkg::fma_op_e     op_i,
  input  logic                 op_mod_i,
  input  fma_pkg::round_mode_e rnd_mode_i,
  output logic                 out_valid_o,
  output fma_pkg::fp16_t       result_o,
  output fma_pkg::flags_t      flags_o
);

  import fma_pkg::*;

  // Prepared operands, shared by both first-stage paths
  fp16_t       op_a;
  fp16_t       op_b;
  fp16_t       op_c;
  op_class_t   class_a;
  op_class_t   class_b;
  op_class_t   class_c;
  // Stage 1 outputs
  logic        valid_s1;
  round_mode_e rnd_mode_s1;
  sum_t        sum_s1;
  logic        eff_sub_s1;
  logic        sign_s1;
  exp_t        exp_product_s1;
  exp_t        exp_diff_s1;
  exp_t        tent_exp_s1;
  shamt_t      addend_shamt_s1;
  logic        sticky_s1;
  logic        is_special_s1;
  fp16_t       special_result_s1;
  flags_t      special_flags_s1;

  fma_operand_prep u_operand_prep (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .rnd_mode_i  (rnd_mode_i),
    .op_a_o      (op_a),
    .op_b_o      (op_b),
    .op_c_o      (op_c),
    .class_a_o   (class_a),
    .class_b_o   (class_b),
    .class_c_o   (class_c)
  );

  fma_special_case u_special_case (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .valid_i          (in_valid_i),
    .op_a_i           (op_a),
    .op_b_i           (op_b),
    .op_c_i           (op_c),
    .class_a_i        (class_a),
    .class_b_i        (class_b),
    .class_c_i        (class_c),
    .is_special_o     (is_special_s1),
    .special_result_o (special_result_s1),
    .special_flags_o  (special_flags_s1)
  );

  fma_mant_datapath u_mant_datapath (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .valid_i        (in_valid_i),
    .rnd_mode_i     (rnd_mode_i),
    .op_a_i         (op_a),
    .op_b_i         (op_b),
    .op_c_i         (op_c),
    .class_a_i      (class_a),
    .class_b_i      (class_b),
    .class_c_i      (class_c),
    .valid_o        (valid_s1),
    .rnd_mode_o     (rnd_mode_s1),
    .sum_o          (sum_s1),
    .eff_sub_o      (eff_sub_s1),
    .sign_o         (sign_s1),
    .exp_product_o  (exp_product_s1),
    .exp_diff_o     (exp_diff_s1),
    .tent_exp_o     (tent_exp_s1),
    .addend_shamt_o (addend_shamt_s1),
    .sticky_o       (sticky_s1)
  );

  fma_norm_round u_norm_round (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .valid_i          (valid_s1),
    .rnd_mode_i       (rnd_mode_s1),
    .sum_i            (sum_s1),
    .eff_sub_i        (eff_sub_s1),
    .sign_i           (sign_s1),
    .exp_product_i    (exp_product_s1),
    .exp_diff_i       (exp_diff_s1),
    .tent_exp_i       (tent_exp_s1),
    .addend_shamt_i   (addend_shamt_s1),
    .sticky_i         (sticky_s1),
    .is_special_i     (is_special_s1),
    .special_result_i (special_result_s1),
    .special_flags_i  (special_flags_s1),
    .result_o         (result_o),
    .flags_o          (flags_o),
    .out_valid_o      (out_valid_o)
  );

  // Operation select feeds both first-stage paths through the prep logic
  op_known_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_valid_i |-> !$isunknown({op_i, op_mod_i, rnd_mode_i}));

endmodule

`default_nettype wire

// ==== fma_top.f ====
+incdir+design
design/fma_pkg.sv
design/fma_operand_prep.sv
design/fma_special_case.sv
design/fma_mant_datapath.sv
design/fma_norm_round.sv
design/fma_top.sv
tests/fma_tb_clock.sv
tests/fma_tb.sv

// ==== tests/fma_tb.sv ====
/* FMA testbench
   Directed tests of the binary16 FMA: arithmetic, special cases, rounding, pipelining */
`default_nettype none

`include "fma_settings.svh"

module fma_tb;

  import fma_pkg::*;

  localparam int timeout_cycles = 10;
  localparam int num_basic = 7;

  // Single flag values
  localparam flags_t flag_nv = flags_t'(1 << `FMA_FLAG_NV);
  localparam flags_t flag_of = flags_t'(1 << `FMA_FLAG_OF);
  localparam flags_t flag_nx = flags_t'(1 << `FMA_FLAG_NX);

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  fp16_t       operand_a;
  fp16_t       operand_b;
  fp16_t       operand_c;
  fma_op_e     op;
  logic        op_mod;
  round_mode_e rnd_mode;
  logic        out_valid;
  fp16_t       result;
  flags_t      flags;

  // Basic operation table, A = 1.5, B = 2.0, C = 0.25
  string       basic_name [num_basic];
  fma_op_e     basic_op [num_basic];
  logic        basic_mod [num_basic];
  fp16_t       basic_res [num_basic];

  fma_tb_clock u_clock (
    .clk_o (clk)
  );

  fma_top dut_i (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .in_valid_i  (in_valid),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operand_c_i (operand_c),
    .op_i        (op),
    .op_mod_i    (op_mod),
    .rnd_mode_i  (rnd_mode),
    .out_valid_o (out_valid),
    .result_o    (result),
    .flags_o     (flags)
  );

  // --------------------
  // Helpers
  // --------------------
  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  // Step to the sampling point 1 unit after the next rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_op(input fp16_t a, input fp16_t b, input fp16_t c,
                          input fma_op_e code, input logic modifier,
                          input round_mode_e mode);
    in_valid  = 1'b1;
    operand_a = a;
    operand_b = b;
    operand_c = c;
    op        = code;
    op_mod    = modifier;
    rnd_mode  = mode;
  endtask

  task automatic wait_for_result();
    int waited;
    waited = 0;
    while (!out_valid && (waited < timeout_cycles)) begin
      next_cycle();
      waited++;
    end
    if (!out_valid) begin
      $display("Timeout: out_valid_o did not rise within %0d cycles", timeout_cycles);
      stop_with_failure();
    end
  endtask

  task automatic fill_basic_table();
    basic_name[0] = "FMADD";
    basic_op[0]   = FMADD;
    basic_mod[0]  = 1'b0;
    basic_res[0]  = 16'h4280;
    basic_name[1] = "FMSUB";
    basic_op[1]   = FMADD;
    basic_mod[1]  = 1'b1;
    basic_res[1]  = 16'h4180;
    basic_name[2] = "FNMSUB";
    basic_op[2]   = FNMSUB;
    basic_mod[2]  = 1'b0;
    basic_res[2]  = 16'hC180;
    basic_name[3] = "FNMADD";
    basic_op[3]   = FNMSUB;
    basic_mod[3]  = 1'b1;
    basic_res[3]  = 16'hC280;
    // ADD and SUB use B and C, A is replaced by 1.0
    basic_name[4] = "ADD";
    basic_op[4]   = ADD;
    basic_mod[4]  = 1'b0;
    basic_res[4]  = 16'h4080;
    basic_name[5] = "SUB";
    basic_op[5]   = ADD;
    basic_mod[5]  = 1'b1;
    basic_res[5]  = 16'h3F00;
    basic_name[6] = "MUL";
    basic_op[6]   = MUL;
    basic_mod[6]  = 1'b0;
    basic_res[6]  = 16'h4200;
  endtask

  // --------------------
  // Directed tests
  // --------------------
  // One operation in an idle pipeline, then the one-cycle strobe
  task automatic run_single(input string name, input fp16_t a, input fp16_t b,
                            input fp16_t c, input fma_op_e code, input logic modifier,
                            input round_mode_e mode, input fp16_t exp_result,
                            input flags_t exp_flags);
    next_cycle();
    drive_op(a, b, c, code, modifier, mode);
    next_cycle();
    in_valid = 1'b0;
    wait_for_result();
    check_value({"result_o (", name, ")"}, result, exp_result);
    check_value({"flags_o (", name, ")"}, flags, exp_flags);
    next_cycle();
    check_value({"out_valid_o after ", name}, out_valid, 1'b0);
  endtask

  task automatic check_reset();
    arst_n = 1'b0;
    repeat (3) begin
      next_cycle();
      check_value("out_valid_o in reset", out_valid, 1'b0);
    end
    arst_n = 1'b1;
    next_cycle();
    check_value("out_valid_o after reset", out_valid, 1'b0);
  endtask

  task automatic check_basic_ops();
    for (int i = 0; i < num_basic; i++) begin
      run_single(basic_name[i], 16'h3E00, 16'h4000, 16'h3400, basic_op[i], basic_mod[i],
                 RNE, basic_res[i], '0);
    end
  endtask

  task automatic check_special_cases();
    run_single("inf x 0", 16'h7C00, 16'h0000, 16'h3C00, FMADD, 1'b0, RNE,
               16'h7E00, flag_nv);
    run_single("sNaN addend", 16'h3C00, 16'h3C00, 16'h7D00, FMADD, 1'b0, RNE,
               16'h7E00, flag_nv);
    run_single("qNaN input", 16'h7E00, 16'h3C00, 16'h3C00, FMADD, 1'b0, RNE,
               16'h7E00, '0);
    // Modifier turns the +inf addend into a subtracted one
    run_single("inf - inf", 16'h7C00, 16'h3C00, 16'h7C00, FMADD, 1'b1, RNE,
               16'h7E00, flag_nv);
    run_single("-inf product", 16'hFC00, 16'h4000, 16'h3C00, FMADD, 1'b0, RNE,
               16'hFC00, '0);
  endtask

  // 1.0 + 2^-11 sits exactly between 1.0 and the next value up
  task automatic check_tie_rounding();
    run_single("tie RNE", 16'h3C00, 16'h3C00, 16'h1000, FMADD, 1'b0, RNE,
               16'h3C00, flag_nx);
    run_single("tie RTZ", 16'h3C00, 16'h3C00, 16'h1000, FMADD, 1'b0, RTZ,
               16'h3C00, flag_nx);
    run_single("tie RDN", 16'h3C00, 16'h3C00, 16'h1000, FMADD, 1'b0, RDN,
               16'h3C00, flag_nx);
    run_single("tie RUP", 16'h3C00, 16'h3C00, 16'h1000, FMADD, 1'b0, RUP,
               16'h3C01, flag_nx);
  endtask

  task automatic check_range_limits();
    run_single("overflow RNE", 16'h7BFF, 16'h4000, 16'h0000, FMADD, 1'b0, RNE,
               16'h7C00, flag_of | flag_nx);
    run_single("overflow RTZ", 16'h7BFF, 16'h4000, 16'h0000, FMADD, 1'b0, RTZ,
               16'h7BFF, flag_of | flag_nx);
    // 2^-14 x 0.5 is exactly representable as a subnormal
    run_single("exact subnormal", 16'h0400, 16'h3800, 16'h0000, FMADD, 1'b0, RNE,
               16'h0200, '0);
  endtask

  // Back-to-back issue, results checked for order and fixed latency
  task automatic check_pipeline();
    int issue_cycle [num_basic];
    int issued;
    int received;
    issued   = 0;
    received = 0;
    for (int cycle = 0; cycle < num_basic + timeout_cycles; cycle++) begin
      next_cycle();
      if (out_valid && (received >= num_basic)) begin
        $display("Extra out_valid_o pulse in the pipelined run at cycle %0d", cycle);
        stop_with_failure();
      end else if (out_valid) begin
        check_value("pipeline latency", cycle, issue_cycle[received] + 2);
        check_value({"result_o (pipelined ", basic_name[received], ")"}, result,
                    basic_res[received]);
        check_value({"flags_o (pipelined ", basic_name[received], ")"}, flags, '0);
        received++;
      end
      // Input driven now is sampled on the next edge
      if (issued < num_basic) begin
        drive_op(16'h3E00, 16'h4000, 16'h3400, basic_op[issued], basic_mod[issued], RNE);
        issue_cycle[issued] = cycle;
        issued++;
      end else begin
        in_valid = 1'b0;
      end
    end
    if (received != num_basic) begin
      $display("Pipelined run produced %0d results instead of %0d", received, num_basic);
      stop_with_failure();
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    operand_a = '0;
    operand_b = '0;
    operand_c = '0;
    op        = FMADD;
    op_mod    = 1'b0;
    rnd_mode  = RNE;
    fill_basic_table();
    check_reset();
    check_basic_ops();
    check_special_cases();
    check_tie_rounding();
    check_range_limits();
    check_pipeline();
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/fma_tb_clock.sv ====
/* FMA testbench clock
   Free-running clock with a period of 8 time units */
`default_nettype none

module fma_tb_clock (
  output logic clk_o
);

  // Starts low, first rising edge at 4
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire
